//--- vlog.f
cpu_pkg.sv
instr_decoder.sv
reg_file.sv
operand_shifter.sv
alu.sv
execute_unit.sv
dp_core.sv
tb_dp_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the dp_core testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_dp_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dp_core | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb_dp_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dp_core;

    localparam int CLK_PERIOD = 40;
    localparam int N_IDLE     = 4;
    localparam int N_SWEEP    = 128;    // Every shift kind and amount once
    localparam int N_IMM      = 32;
    localparam int N_FLAG     = 80;
    localparam int N_COND     = 50;     // Pairs of flag setter and conditional op
    localparam int N_ILLEGAL  = 40;
    localparam int N_ISSUED   = N_IDLE + 16 + N_SWEEP + N_IMM + N_FLAG + 2 * N_COND
                                + N_ILLEGAL + 3;
    localparam int WATCHDOG_NS = (N_ISSUED + 50) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    cpu_pkg::word_t    instr;
    logic              wb_valid;
    cpu_pkg::reg_idx_t wb_reg;
    cpu_pkg::word_t    wb_data;
    cpu_pkg::flags_t   flags;

    cpu_pkg::word_t    model_regs [cpu_pkg::NUM_REGS];
    cpu_pkg::flags_t   model_flags = '0;
    logic              exp_valid = 1'b0;
    cpu_pkg::reg_idx_t exp_reg = '0;
    cpu_pkg::word_t    exp_data = '0;
    logic [32:0]       issue_q [$];    // {valid, word} waiting for execute
    logic [31:0]       rng = 32'hbef1;
    logic [3:0]        last_rd = '0;
    int                errors = 0;
    int                issued = 0;
    int                tests = 0;
    int                mark_errors;
    int                mark_issued;

    cpu_pkg::alu_op_t dp_ops [14] = '{
        cpu_pkg::OP_AND, cpu_pkg::OP_EOR, cpu_pkg::OP_SUB, cpu_pkg::OP_RSB,
        cpu_pkg::OP_ADD, cpu_pkg::OP_ADC, cpu_pkg::OP_SBC, cpu_pkg::OP_RSC,
        cpu_pkg::OP_ORR, cpu_pkg::OP_MOV, cpu_pkg::OP_BIC, cpu_pkg::OP_MVN,
        cpu_pkg::OP_CMP, cpu_pkg::OP_CMN
    };

    dp_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    wb_valid_matches: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == exp_valid)
    else begin
        $display("Mismatch at %0t: wb_valid got %b expected %b", $time,
                 $sampled(wb_valid), exp_valid);
        errors = errors + 1;
    end

    wb_reg_matches: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> wb_reg == exp_reg)
    else begin
        $display("Mismatch at %0t: wb_reg got %0d expected %0d", $time,
                 $sampled(wb_reg), exp_reg);
        errors = errors + 1;
    end

    wb_data_matches: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> wb_data == exp_data)
    else begin
        $display("Mismatch at %0t: wb_data got %h expected %h", $time,
                 $sampled(wb_data), exp_data);
        errors = errors + 1;
    end

    flags_match: assert property (@(posedge clk) disable iff (!rst_n)
        flags == model_flags)
    else begin
        $display("Mismatch at %0t: flags got %b expected %b", $time,
                 $sampled(flags), model_flags);
        errors = errors + 1;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cpu_pkg::word_t ror32(cpu_pkg::word_t value, int n);
        if (n == 0) begin
            return value;
        end
        return (value >> n) | (value << (32 - n));
    endfunction

    function automatic cpu_pkg::word_t operand2(cpu_pkg::word_t word, cpu_pkg::word_t rm_val);
        int amt;
        if (word[25]) begin
            return ror32({24'd0, word[7:0]}, 2 * int'(word[11:8]));
        end
        amt = int'(word[11:7]);
        if (amt == 0) begin
            return rm_val;
        end
        case (word[6:5])
            2'b00:   return rm_val << amt;
            2'b01:   return rm_val >> amt;
            2'b10:   return cpu_pkg::word_t'($signed(rm_val) >>> amt);
            default: return ror32(rm_val, amt);
        endcase
    endfunction

    // Returns {N, Z, C, V, result}
    function automatic logic [35:0] alu_model(logic [3:0] op, cpu_pkg::word_t a,
                                              cpu_pkg::word_t b, logic carry);
        cpu_pkg::word_t x;
        cpu_pkg::word_t y;
        cpu_pkg::word_t r;
        logic           ci;
        logic           c;
        logic           v;
        longint         s;
        ci = carry && (op == cpu_pkg::OP_ADC || op == cpu_pkg::OP_SBC || op == cpu_pkg::OP_RSC);
        x  = (op == cpu_pkg::OP_RSB || op == cpu_pkg::OP_RSC) ? b : a;
        y  = (op == cpu_pkg::OP_RSB || op == cpu_pkg::OP_RSC) ? a : b;
        c  = 1'b0;
        s  = 0;
        case (op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADC, cpu_pkg::OP_CMN: begin
                r = x + y + {31'd0, ci};
                c = (longint'(x) + longint'(y) + longint'(ci)) > 64'sd4294967295;
                s = longint'($signed(x)) + longint'($signed(y)) + longint'(ci);
            end
            cpu_pkg::OP_SUB, cpu_pkg::OP_SBC, cpu_pkg::OP_CMP,
            cpu_pkg::OP_RSB, cpu_pkg::OP_RSC: begin
                r = x - y - {31'd0, ci};
                c = longint'(x) < longint'(y) + longint'(ci);    // Borrow
                s = longint'($signed(x)) - longint'($signed(y)) - longint'(ci);
            end
            cpu_pkg::OP_AND: r = a & b;
            cpu_pkg::OP_EOR: r = a ^ b;
            cpu_pkg::OP_ORR: r = a | b;
            cpu_pkg::OP_MOV: r = b;
            cpu_pkg::OP_BIC: r = a & ~b;
            cpu_pkg::OP_MVN: r = ~b;
            default:         r = '0;
        endcase
        v = (s > 64'sd2147483647) || (s < -64'sd2147483648);
        return {r[31], r == '0, c, v, r};
    endfunction

    function automatic logic cond_holds(logic [3:0] cond, cpu_pkg::flags_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        {n, z, c, v} = f;
        case (cond)
            4'h0:    return z;
            4'h1:    return !z;
            4'h2:    return c;
            4'h3:    return !c;
            4'h4:    return n;
            4'h5:    return !n;
            4'h6:    return v;
            4'h7:    return !v;
            4'h8:    return c && !z;
            4'h9:    return !c || z;
            4'ha:    return n == v;
            4'hb:    return n != v;
            4'hc:    return !z && (n == v);
            4'hd:    return z || (n != v);
            4'he:    return 1'b1;
            default: return 1'b0;    // NV
        endcase
    endfunction

    function automatic cpu_pkg::word_t dp_word(logic [3:0] cond, logic [3:0] op, logic s,
                                               logic [3:0] rn, logic [3:0] rd, logic imm,
                                               logic [11:0] operand);
        return {cond, 2'b00, imm, op, s, rn, rd, operand};
    endfunction

    task automatic apply_model(input logic [32:0] entry);
        cpu_pkg::word_t word;
        logic [3:0]     op;
        logic           supported;
        logic           compare;
        logic [35:0]    out;
        word      = entry[31:0];
        op        = word[24:21];
        supported = entry[32] && word[27:26] == 2'b00 && op != 4'b1000 && op != 4'b1001
                    && (word[25] || !word[4]);
        exp_valid = 1'b0;
        if (supported && cond_holds(word[31:28], model_flags)) begin
            compare = (op == cpu_pkg::OP_CMP) || (op == cpu_pkg::OP_CMN);
            out = alu_model(op, model_regs[word[19:16]], operand2(word, model_regs[word[3:0]]),
                            model_flags[1]);
            if (!compare) begin
                model_regs[word[15:12]] = out[31:0];
                exp_valid = 1'b1;
                exp_reg   = word[15:12];
                exp_data  = out[31:0];
            end
            if (word[20] || compare) begin
                model_flags = out[35:32];
            end
        end
    endtask

    // Drives one cycle and retires the word issued two cycles earlier
    task automatic issue(input logic valid, input cpu_pkg::word_t word);
        @(negedge clk);
        instr_valid = valid;
        instr       = word;
        if (issue_q.size() == 2) begin
            apply_model(issue_q.pop_front());
        end
        issue_q.push_back({valid, word});
        issued = issued + 1;
    endtask

    // shift_sel of 0 to 127 fixes the register shift, below 0 draws any operand
    task automatic issue_random(input logic [3:0] cond, input logic s, input logic all_ops,
                                input int shift_sel);
        int          pick;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic        imm;
        logic [11:0] operand;
        rng  = xorshift(rng);
        pick = int'(rng[7:0]) % (all_ops ? 14 : 12);
        rn   = rng[8] ? last_rd : rng[12:9];    // Often depends on the last result
        rd   = rng[19:16];
        imm  = (shift_sel < 0) && rng[13];
        rng  = xorshift(rng);
        if (imm) begin
            operand = rng[11:0];
        end else if (shift_sel >= 0) begin
            operand = {shift_sel[6:2], shift_sel[1:0], 1'b0, rng[3:0]};
        end else begin
            operand = {rng[11:5], 1'b0, rng[3:0]};
        end
        last_rd = rd;
        issue(1'b1, dp_word(cond, dp_ops[pick], s, rn, rd, imm, operand));
    endtask

    task automatic start_test();
        mark_errors = errors;
        mark_issued = issued;
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("test %0d %s: %0d instructions, %0d mismatches", tests, name,
                 issued - mark_issued, errors - mark_errors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        cpu_pkg::word_t word;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        repeat (N_IDLE) issue(1'b0, '0);
        end_test("reset_state");

        start_test();
        for (int r = 0; r < 16; r++) begin
            rng = xorshift(rng);
            issue(1'b1, dp_word(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, rng[15:12],
                                4'(r), 1'b1, rng[11:0]));
        end
        end_test("mov_immediate");

        start_test();
        for (int i = 0; i < N_SWEEP; i++) begin
            issue_random(cpu_pkg::COND_AL, 1'b0, 1'b0, i);
        end
        repeat (N_IMM) issue_random(cpu_pkg::COND_AL, 1'b0, 1'b0, -1);
        end_test("random_alu");

        start_test();
        for (int i = 0; i < N_FLAG; i++) begin
            rng = xorshift(rng);
            issue_random(cpu_pkg::COND_AL, rng[20], 1'b1, -1);
        end
        end_test("flag_update");

        start_test();
        for (int i = 0; i < N_COND; i++) begin
            issue_random(cpu_pkg::COND_AL, 1'b1, 1'b1, -1);
            rng = xorshift(rng);
            issue_random(rng[31:28], rng[27], 1'b1, -1);
        end
        end_test("conditions");

        start_test();
        for (int i = 0; i < N_ILLEGAL; i++) begin
            rng  = xorshift(rng);
            word = rng;
            word[31:28] = cpu_pkg::COND_AL;
            case (i % 5)
                0: word[27:26] = 2'b01;    // Load or store
                1: word[27:25] = 3'b101;   // Branch
                2: begin
                    word[27:26] = 2'b00;
                    word[24:20] = {3'b100, rng[21], 1'b1};    // TST or TEQ
                end
                3: begin
                    word[27:25] = 3'b000;
                    word[4]     = 1'b1;    // Shift by register
                end
                default: begin
                    word[27:25] = 3'b001;  // Legal word with valid low
                end
            endcase
            issue(i % 5 != 4, word);
        end
        end_test("rejected");

        repeat (3) issue(1'b0, '0);
        $display("%0d tests, %0d instructions, %0d errors", tests, issued, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dp_core.sv
`timescale 1ns/100ps
`default_nettype none

module dp_core (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 instr_valid,
    input  wire cpu_pkg::word_t instr,
    output logic                wb_valid,
    output cpu_pkg::reg_idx_t   wb_reg,
    output cpu_pkg::word_t      wb_data,
    output cpu_pkg::flags_t     flags
);

    cpu_pkg::reg_idx_t rn, rm, dec_rd, rf_waddr;
    cpu_pkg::word_t    rn_data, rm_data, rf_wdata;
    cpu_pkg::cond_t    dec_cond;
    cpu_pkg::alu_op_t  dec_op;
    cpu_pkg::imm12_t   dec_operand;
    logic              dec_valid, dec_set_flags, dec_imm_form;
    logic              rf_we;

    instr_decoder u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rn            (rn),
        .rm            (rm),
        .dec_rd        (dec_rd),
        .dec_valid     (dec_valid),
        .dec_set_flags (dec_set_flags),
        .dec_imm_form  (dec_imm_form),
        .dec_cond      (dec_cond),
        .dec_op        (dec_op),
        .dec_operand   (dec_operand)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rn       (rn),
        .rm       (rm),
        .rf_waddr (rf_waddr),
        .rf_we    (rf_we),
        .rf_wdata (rf_wdata),
        .rn_data  (rn_data),
        .rm_data  (rm_data)
    );

    execute_unit u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_cond      (dec_cond),
        .dec_op        (dec_op),
        .dec_set_flags (dec_set_flags),
        .dec_imm_form  (dec_imm_form),
        .dec_operand   (dec_operand),
        .dec_rd        (dec_rd),
        .rn_data       (rn_data),
        .rm_data       (rm_data),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .wb_valid      (wb_valid),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .flags         (flags)
    );

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    dec_valid,
    input  wire cpu_pkg::cond_t    dec_cond,
    input  wire cpu_pkg::alu_op_t  dec_op,
    input  wire                    dec_set_flags,
    input  wire                    dec_imm_form,
    input  wire cpu_pkg::imm12_t   dec_operand,
    input  wire cpu_pkg::reg_idx_t dec_rd,
    input  wire cpu_pkg::word_t    rn_data,
    input  wire cpu_pkg::word_t    rm_data,
    output logic                   rf_we,
    output cpu_pkg::reg_idx_t      rf_waddr,
    output cpu_pkg::word_t         rf_wdata,
    output logic                   wb_valid,
    output cpu_pkg::reg_idx_t      wb_reg,
    output cpu_pkg::word_t         wb_data,
    output cpu_pkg::flags_t        flags
);

    cpu_pkg::word_t  shifted;
    cpu_pkg::word_t  result;
    cpu_pkg::flags_t alu_flags;
    logic            n_f, z_f, c_f, v_f;
    logic            cond_pass;
    logic            is_compare;

    operand_shifter u_shifter (
        .imm_form (dec_imm_form),
        .operand  (dec_operand),
        .rm_data  (rm_data),
        .shifted  (shifted)
    );

    alu u_alu (
        .op        (dec_op),
        .a         (rn_data),
        .b         (shifted),
        .carry_in  (c_f),
        .result    (result),
        .alu_flags (alu_flags)
    );

    assign {n_f, z_f, c_f, v_f} = flags;

    always_comb begin
        cond_pass = 1'b0;
        case (dec_cond)
            cpu_pkg::COND_EQ: cond_pass = z_f;
            cpu_pkg::COND_NE: cond_pass = !z_f;
            cpu_pkg::COND_CS: cond_pass = c_f;
            cpu_pkg::COND_CC: cond_pass = !c_f;
            cpu_pkg::COND_MI: cond_pass = n_f;
            cpu_pkg::COND_PL: cond_pass = !n_f;
            cpu_pkg::COND_VS: cond_pass = v_f;
            cpu_pkg::COND_VC: cond_pass = !v_f;
            cpu_pkg::COND_HI: cond_pass = c_f && !z_f;
            cpu_pkg::COND_LS: cond_pass = !c_f || z_f;
            cpu_pkg::COND_GE: cond_pass = (n_f == v_f);
            cpu_pkg::COND_LT: cond_pass = (n_f != v_f);
            cpu_pkg::COND_GT: cond_pass = !z_f && (n_f == v_f);
            cpu_pkg::COND_LE: cond_pass = z_f || (n_f != v_f);
            cpu_pkg::COND_AL: cond_pass = 1'b1;
            cpu_pkg::COND_NV: cond_pass = 1'b0;
        endcase
    end

    assign is_compare = (dec_op == cpu_pkg::OP_CMP) || (dec_op == cpu_pkg::OP_CMN);

    assign rf_we    = dec_valid && cond_pass && !is_compare;
    assign rf_waddr = dec_rd;
    assign rf_wdata = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            flags    <= '0;
        end else begin
            wb_valid <= rf_we;
            if (dec_valid && cond_pass && dec_set_flags) begin
                flags <= alu_flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= rf_waddr;
        wb_data <= rf_wdata;
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire                   carry_in,
    output cpu_pkg::word_t        result,
    output cpu_pkg::flags_t       alu_flags
);

    cpu_pkg::word_t x;
    cpu_pkg::word_t y;
    logic           swap;
    logic           cin;
    logic [32:0]    sum;
    logic [32:0]    diff;
    logic           c;
    logic           v;

    always_comb begin
        swap = (op == cpu_pkg::OP_RSB) || (op == cpu_pkg::OP_RSC);
        x    = swap ? b : a;
        y    = swap ? a : b;
        cin  = (op == cpu_pkg::OP_ADC) || (op == cpu_pkg::OP_SBC) || (op == cpu_pkg::OP_RSC);
        cin  = cin && carry_in;

        sum  = {1'b0, x} + {1'b0, y} + {32'd0, cin};
        diff = {1'b0, x} - {1'b0, y} - {32'd0, cin};    // Bit 32 set on borrow

        c = 1'b0;
        v = 1'b0;
        case (op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADC, cpu_pkg::OP_CMN: begin
                result = sum[31:0];
                c      = sum[32];
                v      = ~(x[31] ^ y[31]) & (x[31] ^ sum[31]);
            end
            cpu_pkg::OP_SUB, cpu_pkg::OP_SBC, cpu_pkg::OP_CMP,
            cpu_pkg::OP_RSB, cpu_pkg::OP_RSC: begin
                result = diff[31:0];
                c      = diff[32];
                v      = (x[31] ^ y[31]) & (x[31] ^ diff[31]);
            end
            cpu_pkg::OP_AND: result = a & b;
            cpu_pkg::OP_EOR: result = a ^ b;
            cpu_pkg::OP_ORR: result = a | b;
            cpu_pkg::OP_MOV: result = b;
            cpu_pkg::OP_BIC: result = a & ~b;
            cpu_pkg::OP_MVN: result = ~b;
            default:         result = '0;
        endcase

        alu_flags = {result[31], result == '0, c, v};
    end

endmodule

`default_nettype wire

//--- operand_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module operand_shifter (
    input  wire                  imm_form,
    input  wire cpu_pkg::imm12_t operand,
    input  wire cpu_pkg::word_t  rm_data,
    output cpu_pkg::word_t       shifted
);

    logic [4:0]       rot;
    logic [4:0]       amount;
    cpu_pkg::shift_t  kind;
    logic [63:0]      imm_pair;
    logic [63:0]      reg_pair;

    assign rot    = {operand[11:8], 1'b0};    // Twice the rotate field
    assign amount = operand[11:7];
    assign kind   = cpu_pkg::shift_t'(operand[6:5]);

    // Rotate right done as a shift of the doubled word
    assign imm_pair = {2{24'd0, operand[7:0]}} >> rot;
    assign reg_pair = {rm_data, rm_data} >> amount;

    always_comb begin
        if (imm_form) begin
            shifted = imm_pair[31:0];
        end else if (amount == 5'd0) begin
            shifted = rm_data;
        end else begin
            case (kind)
                cpu_pkg::SH_LSL: shifted = rm_data << amount;
                cpu_pkg::SH_LSR: shifted = rm_data >> amount;
                cpu_pkg::SH_ASR: shifted = $signed(rm_data) >>> amount;
                default:         shifted = reg_pair[31:0];    // ROR
            endcase
        end
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                   clk,
    input  wire cpu_pkg::reg_idx_t rn,
    input  wire cpu_pkg::reg_idx_t rm,
    input  wire cpu_pkg::reg_idx_t rf_waddr,
    input  wire                   rf_we,
    input  wire cpu_pkg::word_t    rf_wdata,
    output cpu_pkg::word_t        rn_data,
    output cpu_pkg::word_t        rm_data
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // Read ports see the old value during a write cycle
    assign rn_data = regs[rn];
    assign rm_data = regs[rm];

endmodule

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                instr_valid,
    input  wire cpu_pkg::word_t instr,
    output cpu_pkg::reg_idx_t  rn,
    output cpu_pkg::reg_idx_t  rm,
    output cpu_pkg::reg_idx_t  dec_rd,
    output logic               dec_valid,
    output logic               dec_set_flags,
    output logic               dec_imm_form,
    output cpu_pkg::cond_t     dec_cond,
    output cpu_pkg::alu_op_t   dec_op,
    output cpu_pkg::imm12_t    dec_operand
);

    cpu_pkg::alu_op_t opcode;
    logic             is_compare;
    logic             is_test;
    logic             data_proc;
    logic             shift_ok;
    logic             supported;

    assign opcode     = cpu_pkg::alu_op_t'(instr[24:21]);
    assign is_compare = (opcode == cpu_pkg::OP_CMP) || (opcode == cpu_pkg::OP_CMN);

    // TST and TEQ have no enum value
    assign is_test   = (instr[24:21] == 4'b1000) || (instr[24:21] == 4'b1001);
    assign data_proc = (instr[27:26] == 2'b00);

    // Register-shifted-by-register has bit 4 set with bit 25 clear
    assign shift_ok  = instr[25] || !instr[4];

    assign supported = instr_valid && data_proc && !is_test && shift_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= supported;
        end
    end

    always_ff @(posedge clk) begin
        rn            <= instr[19:16];
        rm            <= instr[3:0];
        dec_rd        <= instr[15:12];
        dec_cond      <= instr[31:28];
        dec_op        <= opcode;
        dec_imm_form  <= instr[25];
        dec_operand   <= instr[11:0];
        dec_set_flags <= instr[20] || is_compare;    // Compares always set flags
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int NUM_REGS = 16;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  flags_t;    // N Z C V, N on top
    typedef logic [3:0]  cond_t;
    typedef logic [11:0] imm12_t;    // Instruction bits 11:0

    // Instruction opcode field as is, 1000 and 1001 (TST, TEQ) unsupported
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_RSB = 4'b0011,
        OP_ADD = 4'b0100,
        OP_ADC = 4'b0101,
        OP_SBC = 4'b0110,
        OP_RSC = 4'b0111,
        OP_CMP = 4'b1010,
        OP_CMN = 4'b1011,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101,
        OP_BIC = 4'b1110,
        OP_MVN = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shift_t;

    localparam cond_t COND_EQ = 4'b0000;
    localparam cond_t COND_NE = 4'b0001;
    localparam cond_t COND_CS = 4'b0010;
    localparam cond_t COND_CC = 4'b0011;
    localparam cond_t COND_MI = 4'b0100;
    localparam cond_t COND_PL = 4'b0101;
    localparam cond_t COND_VS = 4'b0110;
    localparam cond_t COND_VC = 4'b0111;
    localparam cond_t COND_HI = 4'b1000;
    localparam cond_t COND_LS = 4'b1001;
    localparam cond_t COND_GE = 4'b1010;
    localparam cond_t COND_LT = 4'b1011;
    localparam cond_t COND_GT = 4'b1100;
    localparam cond_t COND_LE = 4'b1101;
    localparam cond_t COND_AL = 4'b1110;
    localparam cond_t COND_NV = 4'b1111;

endpackage

`default_nettype wire
